//--- include/periph_consts.svh
`ifndef PERIPH_CONSTS_SVH
`define PERIPH_CONSTS_SVH

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// peripheral address map
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

// byte base addresses of the two peripherals.
`define PER_CNTRL_BASE    15'h0090
`define PER_TIMER_BASE    15'h00A0

// decode widths count byte address bits inside each window.
`define PER_CNTRL_DEC_WD  2
`define PER_TIMER_DEC_WD  3

// word offsets inside the timer window.
`define TIMER_CTL_OFS     2'd0
`define TIMER_CNT_OFS     2'd1
`define TIMER_CMP_OFS     2'd2

`endif

//--- hdl/per_bus_pkg.sv
package per_bus_pkg;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // peripheral bus types
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // the two byte lanes of a bus word, high lane first.
  typedef struct packed {
    logic [7:0] hi;
    logic [7:0] lo;
  } per_bytes_t;

  // a bus word seen either whole or as two byte lanes.
  typedef union packed {
    logic [15:0] word;
    per_bytes_t  bytes;
  } per_data_u;

  // one bus request as driven by the core.
  // addr is a word address; we holds one strobe per byte lane.
  typedef struct packed {
    logic [13:0] addr;
    per_data_u   din;
    logic        en;
    logic [1:0]  we;
  } per_req_t;

endpackage

//--- hdl/periph_pkg.sv
package periph_pkg;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // peripheral register types
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // timer control word, bit 0 is run.
  // clr is a command and always reads back as zero.
  // flag is sticky and cleared by writing a one to it.
  typedef struct packed {
    logic [11:0] rsvd;
    logic        flag;
    logic        irq_en;
    logic        clr;
    logic        run;
  } timer_ctl_t;

  // the four control bytes as they leave the subsystem.
  typedef struct packed {
    logic [7:0] cntrl4;
    logic [7:0] cntrl3;
    logic [7:0] cntrl2;
    logic [7:0] cntrl1;
  } periph_cntrl_t;

endpackage

//--- hdl/periph_8b_cntrl.sv
`timescale 1ns/1ns
`include "periph_consts.svh"

module periph_8b_cntrl #(
  parameter logic [14:0] BASE_ADDR = `PER_CNTRL_BASE
) (
  input  logic                      mclk,
  input  logic                      puc_rst,
  input  per_bus_pkg::per_req_t     bus_req,
  output logic [15:0]               dout,
  output periph_pkg::periph_cntrl_t cntrl
);

  import per_bus_pkg::*;

  localparam int DEC_WD = `PER_CNTRL_DEC_WD;
  localparam int DEC_SZ = 1 << DEC_WD;

  // byte offsets inside the window, odd offsets use the high lane.
  localparam int CNTRL1 = 0;
  localparam int CNTRL2 = 1;
  localparam int CNTRL3 = 2;
  localparam int CNTRL4 = 3;

  per_data_u              wdata;
  per_data_u              rdata;
  logic                   reg_sel;
  logic [DEC_WD-2:0]      word_ofs;
  logic                   lo_write;
  logic                   hi_write;
  logic                   reg_read;
  logic [DEC_SZ-1:0]      reg_dec;
  logic [DEC_SZ-1:0]      reg_wr;
  logic [DEC_SZ-1:0]      reg_rd;
  logic [DEC_SZ-1:0][7:0] reg_q;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // address decode
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // the word address drops bit 0 of the byte address.
  assign wdata    = bus_req.din;
  assign reg_sel  = bus_req.en & (bus_req.addr[13:DEC_WD-1] == BASE_ADDR[14:DEC_WD]);
  assign word_ofs = bus_req.addr[DEC_WD-2:0];
  assign lo_write = reg_sel & bus_req.we[0];
  assign hi_write = reg_sel & bus_req.we[1];
  assign reg_read = reg_sel & ~|bus_req.we;

  // one-hot select of the byte registers, two per word.
  always_comb begin
    for (int i = 0; i < DEC_SZ; i++) begin
      reg_dec[i] = (word_ofs == i[DEC_WD-1:1]);
      reg_wr[i]  = reg_dec[i] & (i[0] ? hi_write : lo_write);
      reg_rd[i]  = reg_dec[i] & reg_read;
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // registers
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_ff @(posedge mclk or posedge puc_rst) begin
    if (puc_rst) begin
      reg_q <= '0;
    end else begin
      for (int i = 0; i < DEC_SZ; i++) begin
        if (reg_wr[i]) begin
          reg_q[i] <= i[0] ? wdata.bytes.hi : wdata.bytes.lo;
        end
      end
    end
  end

  assign cntrl.cntrl1 = reg_q[CNTRL1];
  assign cntrl.cntrl2 = reg_q[CNTRL2];
  assign cntrl.cntrl3 = reg_q[CNTRL3];
  assign cntrl.cntrl4 = reg_q[CNTRL4];

  // each selected byte goes back on its own lane.
  always_comb begin
    rdata.word = '0;
    for (int i = 0; i < DEC_SZ; i++) begin
      if (reg_rd[i]) begin
        if (i[0]) begin
          rdata.bytes.hi = reg_q[i];
        end else begin
          rdata.bytes.lo = reg_q[i];
        end
      end
    end
  end

  assign dout = rdata.word;

endmodule

//--- hdl/periph_timer_16b.sv
`timescale 1ns/1ns
`include "periph_consts.svh"

module periph_timer_16b #(
  parameter logic [14:0] BASE_ADDR = `PER_TIMER_BASE
) (
  input  logic                  mclk,
  input  logic                  puc_rst,
  input  per_bus_pkg::per_req_t bus_req,
  output logic [15:0]           dout,
  output logic                  irq
);

  import periph_pkg::*;

  localparam int DEC_WD = `PER_TIMER_DEC_WD;

  timer_ctl_t        ctl_wdata;
  timer_ctl_t        ctl_rd;
  logic              reg_sel;
  logic [DEC_WD-2:0] reg_ofs;
  logic              reg_write;
  logic              reg_read;
  logic              ctl_wr;
  logic              cnt_wr;
  logic              cmp_wr;
  logic              clr_cmd;
  logic              match;
  logic              run_q;
  logic              irq_en_q;
  logic              flag_q;
  logic [15:0]       cnt_q;
  logic [15:0]       cmp_q;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // address decode
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // the timer takes whole words, so either strobe makes a write.
  assign reg_sel   = bus_req.en & (bus_req.addr[13:DEC_WD-1] == BASE_ADDR[14:DEC_WD]);
  assign reg_ofs   = bus_req.addr[DEC_WD-2:0];
  assign reg_write = reg_sel & |bus_req.we;
  assign reg_read  = reg_sel & ~|bus_req.we;

  assign ctl_wr = reg_write & (reg_ofs == `TIMER_CTL_OFS);
  assign cnt_wr = reg_write & (reg_ofs == `TIMER_CNT_OFS);
  assign cmp_wr = reg_write & (reg_ofs == `TIMER_CMP_OFS);

  assign ctl_wdata = timer_ctl_t'(bus_req.din.word);
  assign clr_cmd   = ctl_wr & ctl_wdata.clr;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // control, counter and compare
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  assign match = run_q & (cnt_q == cmp_q);

  // a match on the same edge as a flag clear keeps the flag set.
  always_ff @(posedge mclk or posedge puc_rst) begin
    if (puc_rst) begin
      run_q    <= 1'b0;
      irq_en_q <= 1'b0;
      flag_q   <= 1'b0;
    end else begin
      if (ctl_wr) begin
        run_q    <= ctl_wdata.run;
        irq_en_q <= ctl_wdata.irq_en;
      end
      if (match) begin
        flag_q <= 1'b1;
      end else if (ctl_wr & ctl_wdata.flag) begin
        flag_q <= 1'b0;
      end
    end
  end

  // bus write first, then clear, then wrap, then count.
  always_ff @(posedge mclk or posedge puc_rst) begin
    if (puc_rst) begin
      cnt_q <= '0;
    end else if (cnt_wr) begin
      cnt_q <= bus_req.din.word;
    end else if (clr_cmd || match) begin
      cnt_q <= '0;
    end else if (run_q) begin
      cnt_q <= cnt_q + 16'd1;
    end
  end

  always_ff @(posedge mclk or posedge puc_rst) begin
    if (puc_rst) begin
      cmp_q <= '0;
    end else if (cmp_wr) begin
      cmp_q <= bus_req.din.word;
    end
  end

  assign irq = flag_q & irq_en_q;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // read back
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_comb begin
    ctl_rd        = '0;
    ctl_rd.run    = run_q;
    ctl_rd.irq_en = irq_en_q;
    ctl_rd.flag   = flag_q;
  end

  always_comb begin
    dout = '0;
    if (reg_read) begin
      case (reg_ofs)
        `TIMER_CTL_OFS: dout = ctl_rd;
        `TIMER_CNT_OFS: dout = cnt_q;
        `TIMER_CMP_OFS: dout = cmp_q;
        default:        dout = '0;
      endcase
    end
  end

endmodule

//--- hdl/periph_subsys.sv
`timescale 1ns/1ns

module periph_subsys (
  input  logic                      mclk,
  input  logic                      puc_rst,
  input  logic [13:0]               per_addr,
  input  logic [15:0]               per_din,
  input  logic                      per_en,
  input  logic [1:0]                per_we,
  output logic [15:0]               per_dout,
  output periph_pkg::periph_cntrl_t cntrl,
  output logic                      irq
);

  import per_bus_pkg::*;

  per_req_t    bus_req;
  logic [15:0] cntrl_dout;
  logic [15:0] timer_dout;

  // one request struct feeds every peripheral.
  always_comb begin
    bus_req          = '0;
    bus_req.addr     = per_addr;
    bus_req.din.word = per_din;
    bus_req.en       = per_en;
    bus_req.we       = per_we;
  end

  periph_8b_cntrl u_periph_8b_cntrl (
    .mclk    (mclk),
    .puc_rst (puc_rst),
    .bus_req (bus_req),
    .dout    (cntrl_dout),
    .cntrl   (cntrl)
  );

  periph_timer_16b u_periph_timer_16b (
    .mclk    (mclk),
    .puc_rst (puc_rst),
    .bus_req (bus_req),
    .dout    (timer_dout),
    .irq     (irq)
  );

  // unselected peripherals drive zero, so an OR is enough.
  assign per_dout = cntrl_dout | timer_dout;

endmodule

//--- dv/tb_periph_subsys.sv
`timescale 1ns/1ns
`include "periph_consts.svh"

module tb_periph_subsys;

  import periph_pkg::*;

  localparam int CLK_PERIOD      = 100;
  localparam int RAND_SEED       = 21649;
  localparam int N_RANDOM        = 500;
  localparam int DIRECTED_CYCLES = 300;
  localparam int WATCHDOG_CYCLES = 2 * (DIRECTED_CYCLES + N_RANDOM) + 400;
  localparam int MATCH_CMP       = 20;

  // the bus carries word addresses and drops bit 0 of the byte address.
  localparam logic [13:0] CNTRL_W0 = 14'(`PER_CNTRL_BASE >> 1);
  localparam logic [13:0] CNTRL_W1 = CNTRL_W0 + 14'd1;
  localparam logic [13:0] TMR_CTL  = 14'(`PER_TIMER_BASE >> 1) + 14'(`TIMER_CTL_OFS);
  localparam logic [13:0] TMR_CNT  = 14'(`PER_TIMER_BASE >> 1) + 14'(`TIMER_CNT_OFS);
  localparam logic [13:0] TMR_CMP  = 14'(`PER_TIMER_BASE >> 1) + 14'(`TIMER_CMP_OFS);

  localparam logic [13:0] UNMAPPED [7] = '{14'h0000, CNTRL_W0 - 14'd1, CNTRL_W1 + 14'd1,
                                          TMR_CTL - 14'd1, TMR_CMP + 14'd1, TMR_CMP + 14'd2,
                                          14'h3FFF};
  localparam logic [13:0] RAND_ADDRS [6] = '{CNTRL_W0, CNTRL_W1, TMR_CTL, TMR_CNT, TMR_CMP,
                                            TMR_CMP + 14'd1};

  logic          mclk;
  logic          puc_rst;
  logic [13:0]   per_addr;
  logic [15:0]   per_din;
  logic          per_en;
  logic [1:0]    per_we;
  logic [15:0]   per_dout;
  periph_cntrl_t cntrl;
  logic          irq;

  logic [7:0]    m_byte [4];
  logic          m_run;
  logic          m_irq_en;
  logic          m_flag;
  logic [15:0]   m_cnt;
  logic [15:0]   m_cmp;
  logic          m_wr;
  logic          m_ctl_wr;
  logic          m_match;
  logic [15:0]   exp_dout;
  logic [31:0]   exp_cntrl;
  int unsigned   rnd;
  int            dout_errs = 0;
  int            cntrl_errs = 0;
  int            irq_errs = 0;
  int            step_errs = 0;
  int            wait_errs = 0;

  periph_subsys u_periph_subsys (
    .mclk     (mclk),
    .puc_rst  (puc_rst),
    .per_addr (per_addr),
    .per_din  (per_din),
    .per_en   (per_en),
    .per_we   (per_we),
    .per_dout (per_dout),
    .cntrl    (cntrl),
    .irq      (irq)
  );

  initial begin
    mclk = 1'b0;
    forever #(CLK_PERIOD / 2) mclk = ~mclk;
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // reference model
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  assign m_wr     = per_en & (per_we != 2'b00);
  assign m_ctl_wr = m_wr & (per_addr == TMR_CTL);
  assign m_match  = m_run & (m_cnt == m_cmp);

  always @(posedge mclk or posedge puc_rst) begin
    if (puc_rst) begin
      m_byte   <= '{default: 8'h00};
      m_run    <= 1'b0;
      m_irq_en <= 1'b0;
      m_flag   <= 1'b0;
      m_cnt    <= 16'h0000;
      m_cmp    <= 16'h0000;
    end else begin
      // byte i lives in word i/2 and odd bytes take the high lane.
      for (int i = 0; i < 4; i++) begin
        if (m_wr && per_addr == CNTRL_W0 + 14'(i / 2) && per_we[i % 2]) begin
          m_byte[i] <= per_din[8 * (i % 2) +: 8];
        end
      end
      if (m_ctl_wr) begin
        m_run    <= per_din[0];
        m_irq_en <= per_din[2];
      end
      if (m_match) begin
        m_flag <= 1'b1;
      end else if (m_ctl_wr && per_din[3]) begin
        m_flag <= 1'b0;
      end
      if (m_wr && per_addr == TMR_CNT) begin
        m_cnt <= per_din;
      end else if ((m_ctl_wr && per_din[1]) || m_match) begin
        m_cnt <= 16'h0000;
      end else if (m_run) begin
        m_cnt <= m_cnt + 16'd1;
      end
      if (m_wr && per_addr == TMR_CMP) begin
        m_cmp <= per_din;
      end
    end
  end

  always_comb begin
    exp_dout = 16'h0000;
    if (per_en && per_we == 2'b00) begin
      case (per_addr)
        CNTRL_W0: exp_dout = {m_byte[1], m_byte[0]};
        CNTRL_W1: exp_dout = {m_byte[3], m_byte[2]};
        TMR_CTL:  exp_dout = {12'h000, m_flag, m_irq_en, 1'b0, m_run};
        TMR_CNT:  exp_dout = m_cnt;
        TMR_CMP:  exp_dout = m_cmp;
        default:  exp_dout = 16'h0000;
      endcase
    end
  end

  assign exp_cntrl = {m_byte[3], m_byte[2], m_byte[1], m_byte[0]};

  a_dout: assert property (@(posedge mclk) disable iff (puc_rst) per_dout == exp_dout)
    else begin
      dout_errs = dout_errs + 1;
      $display("[ERROR] %0t per_dout 0x%04h, expected 0x%04h at word 0x%04h",
               $time, $sampled(per_dout), $sampled(exp_dout), $sampled(per_addr));
    end

  a_cntrl: assert property (@(posedge mclk) disable iff (puc_rst) cntrl == exp_cntrl)
    else begin
      cntrl_errs = cntrl_errs + 1;
      $display("[ERROR] %0t cntrl 0x%08h, expected 0x%08h",
               $time, $sampled(cntrl), $sampled(exp_cntrl));
    end

  a_irq: assert property (@(posedge mclk) disable iff (puc_rst) irq == (m_flag & m_irq_en))
    else begin
      irq_errs = irq_errs + 1;
      $display("[ERROR] %0t irq %0b, expected %0b",
               $time, $sampled(irq), $sampled(m_flag) & $sampled(m_irq_en));
    end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // bus tasks
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  task automatic bus_drive(input logic [13:0] addr, input logic [15:0] din,
                           input logic [1:0] we, input logic en);
    @(negedge mclk);
    per_addr = addr;
    per_din  = din;
    per_we   = we;
    per_en   = en;
  endtask

  task automatic bus_write(input logic [13:0] addr, input logic [15:0] din,
                           input logic [1:0] we);
    bus_drive(addr, din, we, 1'b1);
  endtask

  // read data settles in the access cycle and is taken mid-cycle.
  task automatic bus_read(input logic [13:0] addr, output logic [15:0] data);
    bus_drive(addr, 16'h0000, 2'b00, 1'b1);
    #(CLK_PERIOD / 4);
    data = per_dout;
  endtask

  // idle cycles still carry random address and strobes with en low.
  task automatic bus_idle(input int cycles);
    repeat (cycles) bus_drive(14'($urandom), 16'($urandom), 2'($urandom), 1'b0);
  endtask

  task automatic read_all_regs();
    logic [15:0] data;
    bus_read(CNTRL_W0, data);
    bus_read(CNTRL_W1, data);
    bus_read(TMR_CTL, data);
    bus_read(TMR_CNT, data);
    bus_read(TMR_CMP, data);
  endtask

  task automatic check_count_step(input int k);
    logic [15:0] first;
    logic [15:0] second;
    logic [15:0] step;
    bus_read(TMR_CNT, first);
    bus_idle(k - 1);
    bus_read(TMR_CNT, second);
    step = second - first;
    a_step: assert (step == 16'(k)) else begin
      step_errs = step_errs + 1;
      $display("[ERROR] %0t counter advanced by %0d in %0d cycles", $time, step, k);
    end
  endtask

  task automatic wait_for_irq(input int max_cycles);
    int n;
    n = 0;
    while (!irq && n < max_cycles) begin
      bus_idle(1);
      n++;
    end
    a_irq_rise: assert (irq) else begin
      wait_errs = wait_errs + 1;
      $display("irq did not rise within %0d cycles of waiting", max_cycles);
    end
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // test sequence
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  initial begin
    logic [15:0] rdata;
    logic [13:0] addr;
    int          sel;
    int          total;
    rnd      = $urandom(RAND_SEED);
    puc_rst  = 1'b1;
    per_addr = 14'h0000;
    per_din  = 16'h0000;
    per_en   = 1'b0;
    per_we   = 2'b00;
    repeat (2) @(posedge mclk);
    @(negedge mclk);
    puc_rst = 1'b0;

    bus_idle(2);
    read_all_regs();

    // each strobe touches only its own byte lane.
    bus_write(CNTRL_W0, 16'hA55A, 2'b01);
    bus_read(CNTRL_W0, rdata);
    bus_write(CNTRL_W0, 16'h3CC3, 2'b10);
    bus_read(CNTRL_W0, rdata);
    bus_write(CNTRL_W1, 16'h1234, 2'b11);
    bus_write(CNTRL_W1, 16'hFF00, 2'b10);
    bus_read(CNTRL_W1, rdata);

    foreach (UNMAPPED[i]) begin
      bus_read(UNMAPPED[i], rdata);
      bus_write(UNMAPPED[i], 16'hFFFF, 2'b11);
    end
    read_all_regs();

    bus_write(TMR_CMP, 16'hFFFF, 2'b11);
    bus_write(TMR_CNT, 16'h1000, 2'b01);
    bus_write(TMR_CTL, 16'h0001, 2'b11);
    check_count_step(1);
    check_count_step(5);
    check_count_step(17);
    bus_write(TMR_CNT, 16'hBEEF, 2'b10);
    bus_read(TMR_CNT, rdata);
    bus_write(TMR_CTL, 16'h0003, 2'b11);
    bus_read(TMR_CNT, rdata);
    bus_write(TMR_CTL, 16'h0000, 2'b11);

    // the flag sets with irq_en low, so irq must stay low until enabled.
    bus_write(TMR_CMP, 16'(MATCH_CMP), 2'b11);
    bus_write(TMR_CNT, 16'h0000, 2'b11);
    bus_write(TMR_CTL, 16'h0001, 2'b11);
    bus_idle(MATCH_CMP + 4);
    bus_read(TMR_CTL, rdata);
    bus_write(TMR_CTL, 16'h0005, 2'b11);
    wait_for_irq(4);
    bus_write(TMR_CTL, 16'h000D, 2'b11);
    bus_idle(1);
    wait_for_irq(MATCH_CMP + 4);
    bus_write(TMR_CTL, 16'h0008, 2'b11);
    bus_idle(2);

    for (int n = 0; n < N_RANDOM; n++) begin
      sel  = $urandom_range(0, 7);
      addr = (sel < 6) ? RAND_ADDRS[sel] : 14'($urandom);
      bus_drive(addr, 16'($urandom), 2'($urandom), $urandom_range(0, 7) != 0);
    end
    bus_idle(2);

    total = dout_errs + cntrl_errs + irq_errs + step_errs + wait_errs;
    $display("errors: per_dout %0d, cntrl %0d, irq %0d, counter step %0d, irq wait %0d",
             dout_errs, cntrl_errs, irq_errs, step_errs, wait_errs);
    if (total == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

  initial begin
    #(CLK_PERIOD * WATCHDOG_CYCLES);
    $display("watchdog expired after %0d cycles, the test did not finish", WATCHDOG_CYCLES);
    $display("=== FAIL ===");
    $finish;
  end

endmodule

//--- sim.f
+incdir+include
hdl/per_bus_pkg.sv
hdl/periph_pkg.sv
hdl/periph_8b_cntrl.sv
hdl/periph_timer_16b.sv
hdl/periph_subsys.sv
dv/tb_periph_subsys.sv

//--- run_sim.sh
#!/bin/bash
# Compile and run the testbench with Verilator, then check the log.
set -e
set -o pipefail

cd "$(dirname "$0")"

LOG=sim.log
TOP=tb_periph_subsys

verilator --binary --timing --assert \
  --top-module "$TOP" \
  -Mdir obj_dir \
  -f sim.f

./obj_dir/V"$TOP" 2>&1 | tee "$LOG"

if grep -q "=== FAIL ===" "$LOG"; then
  echo "simulation failed, see $LOG"
  exit 1
fi

echo "simulation passed"
exit 0
